/* sim.f */
+incdir+verilog
verilog/ss_pkg.sv
verilog/ss_issue.sv
verilog/ss_regfile.sv
verilog/ss_lane.sv
verilog/ss_drain.sv
verilog/ss_core.sv
testbench/ss_properties.sv
testbench/ss_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the ss_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module ss_tb \
    -f sim.f \
    --Mdir obj_dir -o ss_sim

# the simulator status is not trusted alone, the log decides
./obj_dir/ss_sim 2>&1 | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* testbench/ss_stim.txt */
// columns: insn(16) expected result or store data(16) store address(16) pair flag(4)
// pair flag 1 means the line retires in the same cycle as the next line
9205_0005_0000_1
95FD_FFFD_0000_0
1642_0002_0000_0
18E4_0006_0000_1
5A5B_0007_0000_0
9C10_0010_0000_1
1F54_0001_0000_0
7F82_0001_0012_0
6382_0001_0000_0
1445_0008_0000_1
577E_0006_0000_0
5893_000E_0000_1
75BF_0008_000F_0
6BBF_0008_0000_1
1DA1_0011_0000_0
6E03_0009_0000_0
11C7_0012_0000_0

/* testbench/ss_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ss_cfg.svh"

module ss_tb;

    localparam int MAX_LINES = 32;

    logic                gwe;
    logic                rst_n;
    logic [`SS_XLEN-1:0] insn_a;
    logic [`SS_XLEN-1:0] insn_b;
    logic [`SS_XLEN-1:0] dmem_rdata;
    logic [`SS_XLEN-1:0] pc;
    logic [`SS_XLEN-1:0] dmem_addr;
    logic [`SS_XLEN-1:0] dmem_wdata;
    logic                dmem_we;
    ss_pkg::ss_retire_t  retire [`SS_LANES];

    // insn, expected value, store address, pair flag
    logic [51:0]         stim [MAX_LINES];
    logic [`SS_XLEN-1:0] dmem [65536];
    logic [`SS_XLEN-1:0] st_addr_q [$];
    logic [`SS_XLEN-1:0] st_data_q [$];
    int                  n_lines;
    int                  next_line;
    int                  cycles;
    int                  limit;

    ss_core dut_i (
        .gwe          (gwe),
        .i_rst_n      (rst_n),
        .i_insn_a     (insn_a),
        .i_insn_b     (insn_b),
        .i_dmem_rdata (dmem_rdata),
        .o_pc         (pc),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .o_retire     (retire)
    );

    initial begin
        gwe = 1'b0;
        forever #10 gwe = ~gwe;
    end

    // words past the program read as NOP
    function automatic logic [`SS_XLEN-1:0] fetch_word(input logic [`SS_XLEN-1:0] addr);
        int idx;
        idx = int'(addr) - int'(`SS_RESET_PC);
        if (idx >= 0 && idx < n_lines) begin
            return stim[idx][51:36];
        end
        return '0;
    endfunction

    task automatic expect_eq(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_with(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic verify_idle();
        expect_eq("o_retire[0].valid", {15'd0, retire[0].valid}, 16'd0);
        expect_eq("o_retire[1].valid", {15'd0, retire[1].valid}, 16'd0);
        expect_eq("o_dmem_we", {15'd0, dmem_we}, 16'd0);
        expect_eq("o_dmem_addr", dmem_addr, 16'd0);
    endtask

    // program lines retire in order from the reset pc
    task automatic score_retire(input int lane, input ss_pkg::ss_retire_t r,
                                input logic partner);
        logic [51:0]         line;
        logic [`SS_XLEN-1:0] word;
        logic                writes;
        logic [`SS_XLEN-1:0] got_addr;
        logic [`SS_XLEN-1:0] got_data;
        if (next_line >= n_lines) begin
            stop_with("an instruction retired after the end of the program");
        end else begin
            line   = stim[next_line];
            word   = line[51:36];
            // every kept instruction except STR writes its rd field
            writes = (word[15:12] != 4'b0111);
            expect_eq($sformatf("o_retire[%0d].insn", lane), r.insn, word);
            expect_eq($sformatf("o_retire[%0d].pc", lane), r.pc,
                      16'(`SS_RESET_PC + next_line));
            expect_eq($sformatf("o_retire[%0d].rd_we", lane),
                      {15'd0, r.rd_we}, {15'd0, writes});
            if (writes) begin
                expect_eq($sformatf("o_retire[%0d].rd", lane),
                          {13'd0, r.rd}, {13'd0, word[11:9]});
            end
            expect_eq($sformatf("o_retire[%0d].data", lane), r.data, line[35:20]);
            if (!writes) begin
                if (st_addr_q.size() == 0) begin
                    stop_with("a store retired without writing data memory");
                end else begin
                    got_addr = st_addr_q.pop_front();
                    got_data = st_data_q.pop_front();
                    expect_eq("o_dmem_addr", got_addr, line[19:4]);
                    expect_eq("o_dmem_wdata", got_data, line[35:20]);
                end
            end
            expect_eq("pair flag", {15'd0, partner}, {12'd0, line[3:0]});
            next_line++;
        end
    endtask

    // memory models and retire checks all work on stable values at the falling edge
    always @(negedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr] = dmem_wdata;
            st_addr_q.push_back(dmem_addr);
            st_data_q.push_back(dmem_wdata);
        end
        insn_a     = fetch_word(pc);
        insn_b     = fetch_word(pc + 16'd1);
        dmem_rdata = dmem[dmem_addr];

        if (retire[0].valid && retire[0].insn.r.opcode != 4'b0000) begin
            score_retire(0, retire[0],
                         retire[1].valid && retire[1].insn.r.opcode != 4'b0000);
        end
        if (retire[1].valid && retire[1].insn.r.opcode != 4'b0000) begin
            score_retire(1, retire[1], 1'b0);
        end

        if (rst_n) begin
            cycles++;
            if (cycles > limit) begin
                stop_with("timeout: the program did not retire within the cycle limit");
            end
        end
    end

    initial begin
        rst_n      = 1'b0;
        insn_a     = '0;
        insn_b     = '0;
        dmem_rdata = '0;
        next_line  = 0;
        cycles     = 0;
        n_lines    = 0;
        for (int a = 0; a < 65536; a++) begin
            dmem[a] = 16'(a * 3);
        end
        for (int k = 0; k < MAX_LINES; k++) begin
            stim[k] = '1;
        end
        $readmemh("testbench/ss_stim.txt", stim);
        for (int k = 0; k < MAX_LINES; k++) begin
            if (stim[k] != '1) begin
                n_lines = k + 1;
            end
        end
        limit = 3 * n_lines + 20;
        if (n_lines == 0) begin
            stop_with("the stimulus file holds no program lines");
        end

        repeat (3) begin
            @(negedge gwe);
            #1;
            verify_idle();
            expect_eq("o_pc", pc, `SS_RESET_PC);
        end
        rst_n = 1'b1;
        #1;
        expect_eq("o_pc", pc, `SS_RESET_PC);
        // D is still empty, so nothing reaches the memory port or retire yet
        @(negedge gwe);
        #1;
        verify_idle();

        wait (next_line == n_lines);
        // a few more cycles catch stray retirements
        repeat (4) @(negedge gwe);
        #1;
        if (st_addr_q.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_with("a data memory write had no matching store in the program");
        end
    end

endmodule

`default_nettype wire

/* testbench/ss_properties.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ss_cfg.svh"

module ss_properties (
    input wire                  gwe,
    input wire                  i_rst_n,
    input wire  [`SS_XLEN-1:0]  i_pc,
    input wire                  i_dmem_we,
    input ss_pkg::ss_retire_t   i_retire  [`SS_LANES],
    input ss_pkg::ss_mem_req_t  i_mem_req [`SS_LANES]
);

    // lane B never retires alone
    retire_b_needs_a: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_retire[1].valid |-> i_retire[0].valid)
        else $error("lane B retired without lane A");

    // a retiring pair sits at consecutive addresses
    retire_pair_order: assert property (@(posedge gwe) disable iff (!i_rst_n)
        (i_retire[0].valid && i_retire[1].valid)
            |-> i_retire[1].pc == i_retire[0].pc + `SS_XLEN'd1)
        else $error("retiring pair is not in program order");

    pc_step: assert property (@(posedge gwe) disable iff (!i_rst_n)
        (i_pc == $past(i_pc)) || (i_pc == $past(i_pc) + `SS_XLEN'd1)
            || (i_pc == $past(i_pc) + `SS_XLEN'd2))
        else $error("fetch pc moved by more than two");

    // one data memory port, so one requesting lane
    dmem_one_lane: assert property (@(posedge gwe) disable iff (!i_rst_n)
        i_dmem_we |-> (i_mem_req[0].valid ^ i_mem_req[1].valid))
        else $error("data memory write without exactly one requesting lane");

endmodule

bind ss_core ss_properties props_i (
    .gwe       (gwe),
    .i_rst_n   (i_rst_n),
    .i_pc      (o_pc),
    .i_dmem_we (o_dmem_we),
    .i_retire  (retire),
    .i_mem_req (mem_req)
);

`default_nettype wire

/* verilog/ss_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ss_cfg.svh"

module ss_core (
    input  wire                 gwe,
    input  wire                 i_rst_n,
    input  wire  [`SS_XLEN-1:0] i_insn_a,
    input  wire  [`SS_XLEN-1:0] i_insn_b,
    input  wire  [`SS_XLEN-1:0] i_dmem_rdata,
    output logic [`SS_XLEN-1:0] o_pc,
    output logic [`SS_XLEN-1:0] o_dmem_addr,
    output logic                o_dmem_we,
    output logic [`SS_XLEN-1:0] o_dmem_wdata,
    output ss_pkg::ss_retire_t  o_retire [`SS_LANES]
);

    wire ss_pkg::ss_issue_t   issue   [`SS_LANES];
    wire ss_pkg::ss_fwd_t     x_fwd   [`SS_LANES];
    wire ss_pkg::ss_fwd_t     m_fwd   [`SS_LANES];
    wire ss_pkg::ss_fwd_t     w_fwd   [`SS_LANES];
    wire ss_pkg::ss_mem_req_t mem_req [`SS_LANES];
    wire ss_pkg::ss_retire_t  retire  [`SS_LANES];
    wire [`SS_RSEL-1:0]       rs_sel  [`SS_LANES];
    wire [`SS_RSEL-1:0]       rt_sel  [`SS_LANES];
    wire [`SS_XLEN-1:0]       rs_data [`SS_LANES];
    wire [`SS_XLEN-1:0]       rt_data [`SS_LANES];

    ss_issue issue_i (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_insn_a  (i_insn_a),
        .i_insn_b  (i_insn_b),
        .i_x_fwd   (x_fwd),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .o_pc      (o_pc),
        .o_rs_sel  (rs_sel),
        .o_rt_sel  (rt_sel),
        .o_issue   (issue)
    );

    ss_regfile regfile_i (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .i_wb      (w_fwd),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // index 0 is lane A and always holds the older instruction
    for (genvar g = 0; g < `SS_LANES; g++) begin : g_lane
        ss_lane lane_i (
            .gwe          (gwe),
            .i_rst_n      (i_rst_n),
            .i_issue      (issue[g]),
            .i_m_fwd      (m_fwd),
            .i_w_fwd      (w_fwd),
            .i_dmem_rdata (i_dmem_rdata),
            .o_x_fwd      (x_fwd[g]),
            .o_m_fwd      (m_fwd[g]),
            .o_w_fwd      (w_fwd[g]),
            .o_mem_req    (mem_req[g]),
            .o_retire     (retire[g])
        );
    end

    ss_drain drain_i (
        .i_mem_req    (mem_req),
        .i_retire     (retire),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .o_retire     (o_retire)
    );

endmodule

`default_nettype wire

/* verilog/ss_drain.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ss_cfg.svh"

module ss_drain (
    input  ss_pkg::ss_mem_req_t  i_mem_req [`SS_LANES],
    input  ss_pkg::ss_retire_t   i_retire  [`SS_LANES],
    output logic [`SS_XLEN-1:0]  o_dmem_addr,
    output logic                 o_dmem_we,
    output logic [`SS_XLEN-1:0]  o_dmem_wdata,
    output ss_pkg::ss_retire_t   o_retire  [`SS_LANES]
);

    // issue never pairs two memory operations, so at most one lane requests
    always_comb begin
        o_dmem_addr  = '0;
        o_dmem_we    = 1'b0;
        o_dmem_wdata = '0;
        for (int i = 0; i < `SS_LANES; i++) begin
            if (i_mem_req[i].valid) begin
                o_dmem_addr  = i_mem_req[i].addr;
                o_dmem_we    = i_mem_req[i].we;
                o_dmem_wdata = i_mem_req[i].wdata;
            end
        end
    end

    // a younger lane only shows up next to an older one
    always_comb begin
        o_retire[0] = i_retire[0];
        for (int i = 1; i < `SS_LANES; i++) begin
            o_retire[i] = i_retire[0].valid ? i_retire[i] : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/ss_lane.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ss_cfg.svh"

module ss_lane (
    input  wire                  gwe,
    input  wire                  i_rst_n,
    input  ss_pkg::ss_issue_t    i_issue,
    input  ss_pkg::ss_fwd_t      i_m_fwd [`SS_LANES],
    input  ss_pkg::ss_fwd_t      i_w_fwd [`SS_LANES],
    input  wire  [`SS_XLEN-1:0]  i_dmem_rdata,
    output ss_pkg::ss_fwd_t      o_x_fwd,
    output ss_pkg::ss_fwd_t      o_m_fwd,
    output ss_pkg::ss_fwd_t      o_w_fwd,
    output ss_pkg::ss_mem_req_t  o_mem_req,
    output ss_pkg::ss_retire_t   o_retire
);

    logic                x_valid;
    ss_pkg::ss_issue_t   x_q;
    logic [`SS_XLEN-1:0] x_rs;
    logic [`SS_XLEN-1:0] x_rt;
    logic [`SS_XLEN-1:0] x_opb;
    logic [`SS_XLEN-1:0] x_alu;

    logic                m_valid;
    logic [`SS_XLEN-1:0] m_pc;
    ss_pkg::ss_insn_u    m_insn;
    ss_pkg::ss_ctrl_t    m_ctrl;
    logic [`SS_XLEN-1:0] m_alu;
    logic [`SS_XLEN-1:0] m_rt;
    logic [`SS_XLEN-1:0] m_st_data;

    logic                w_valid;
    logic [`SS_XLEN-1:0] w_pc;
    ss_pkg::ss_insn_u    w_insn;
    ss_pkg::ss_ctrl_t    w_ctrl;
    logic [`SS_XLEN-1:0] w_data;

    // later matches override earlier ones, so sources go from oldest to youngest
    function automatic logic [`SS_XLEN-1:0] x_operand(input logic [`SS_RSEL-1:0] sel,
                                                      input logic [`SS_XLEN-1:0] rf_val);
        logic [`SS_XLEN-1:0] val;
        val = rf_val;
        for (int j = 0; j < `SS_LANES; j++) begin
            if (i_w_fwd[j].we && i_w_fwd[j].rd == sel) begin
                val = i_w_fwd[j].value;
            end
        end
        // a load in M has no value yet
        for (int j = 0; j < `SS_LANES; j++) begin
            if (i_m_fwd[j].we && !i_m_fwd[j].is_load && i_m_fwd[j].rd == sel) begin
                val = i_m_fwd[j].value;
            end
        end
        return val;
    endfunction

    always_comb begin
        x_rs  = x_operand(x_q.ctrl.rs_sel, x_q.rs_data);
        x_rt  = x_operand(x_q.ctrl.rt_sel, x_q.rt_data);
        x_opb = x_q.ctrl.rt_re ? x_rt : x_q.ctrl.imm;
        case (x_q.ctrl.alu_op)
            ss_pkg::alu_add:      x_alu = x_rs + x_opb;
            ss_pkg::alu_sub:      x_alu = x_rs - x_opb;
            ss_pkg::alu_and:      x_alu = x_rs & x_opb;
            ss_pkg::alu_or:       x_alu = x_rs | x_opb;
            ss_pkg::alu_xor:      x_alu = x_rs ^ x_opb;
            ss_pkg::alu_pass_imm: x_alu = x_q.ctrl.imm;
            ss_pkg::alu_addr:     x_alu = x_rs + x_q.ctrl.imm;
            default:              x_alu = '0;
        endcase
    end

    // store data, W sources first, then MM from lane A
    always_comb begin
        m_st_data = m_rt;
        for (int j = 0; j < `SS_LANES; j++) begin
            if (i_w_fwd[j].we && i_w_fwd[j].rd == m_ctrl.rt_sel) begin
                m_st_data = i_w_fwd[j].value;
            end
        end
        // in lane A this M source is the store itself and never writes a register
        if (i_m_fwd[0].we && !i_m_fwd[0].is_load && i_m_fwd[0].rd == m_ctrl.rt_sel) begin
            m_st_data = i_m_fwd[0].value;
        end
    end

    assign o_x_fwd = '{we:      x_valid && x_q.ctrl.rd_we,
                       rd:      x_q.ctrl.rd_sel,
                       is_load: x_q.ctrl.is_load,
                       value:   x_alu};
    assign o_m_fwd = '{we:      m_valid && m_ctrl.rd_we,
                       rd:      m_ctrl.rd_sel,
                       is_load: m_ctrl.is_load,
                       value:   m_alu};
    assign o_w_fwd = '{we:      w_valid && w_ctrl.rd_we,
                       rd:      w_ctrl.rd_sel,
                       is_load: w_ctrl.is_load,
                       value:   w_data};

    assign o_mem_req = '{valid: m_valid && (m_ctrl.is_load || m_ctrl.is_store),
                         we:    m_valid && m_ctrl.is_store,
                         addr:  m_alu,
                         wdata: m_st_data};

    assign o_retire = '{valid: w_valid,
                        pc:    w_pc,
                        insn:  w_insn,
                        rd_we: w_valid && w_ctrl.rd_we,
                        rd:    w_ctrl.rd_sel,
                        data:  w_data};

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            x_valid <= 1'b0;
            m_valid <= 1'b0;
            w_valid <= 1'b0;
        end else begin
            x_valid <= i_issue.valid;
            m_valid <= x_valid;
            w_valid <= m_valid;
        end
    end

    always_ff @(posedge gwe) begin
        x_q    <= i_issue;
        m_pc   <= x_q.pc;
        m_insn <= x_q.insn;
        m_ctrl <= x_q.ctrl;
        m_alu  <= x_alu;
        m_rt   <= x_rt;
        w_pc   <= m_pc;
        w_insn <= m_insn;
        w_ctrl <= m_ctrl;
        // the trace shows store data in place of a result
        if (m_ctrl.is_load) begin
            w_data <= i_dmem_rdata;
        end else if (m_ctrl.is_store) begin
            w_data <= m_st_data;
        end else begin
            w_data <= m_alu;
        end
    end

endmodule

`default_nettype wire

/* verilog/ss_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ss_cfg.svh"

module ss_regfile (
    input  wire                  gwe,
    input  wire                  i_rst_n,
    input  wire  [`SS_RSEL-1:0]  i_rs_sel  [`SS_LANES],
    input  wire  [`SS_RSEL-1:0]  i_rt_sel  [`SS_LANES],
    input  ss_pkg::ss_fwd_t      i_wb      [`SS_LANES],
    output logic [`SS_XLEN-1:0]  o_rs_data [`SS_LANES],
    output logic [`SS_XLEN-1:0]  o_rt_data [`SS_LANES]
);

    logic [`SS_XLEN-1:0] regs [`SS_NREG];

    // write-through of the W results
    // lane B is younger and is checked last
    function automatic logic [`SS_XLEN-1:0] read_port(input logic [`SS_RSEL-1:0] sel);
        logic [`SS_XLEN-1:0] val;
        val = regs[sel];
        for (int j = 0; j < `SS_LANES; j++) begin
            if (i_wb[j].we && i_wb[j].rd == sel) begin
                val = i_wb[j].value;
            end
        end
        return val;
    endfunction

    always_comb begin
        for (int i = 0; i < `SS_LANES; i++) begin
            o_rs_data[i] = read_port(i_rs_sel[i]);
            o_rt_data[i] = read_port(i_rt_sel[i]);
        end
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < `SS_NREG; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int j = 0; j < `SS_LANES; j++) begin
                if (i_wb[j].we) begin
                    regs[i_wb[j].rd] <= i_wb[j].value;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/ss_issue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ss_cfg.svh"

module ss_issue (
    input  wire                  gwe,
    input  wire                  i_rst_n,
    input  wire  [`SS_XLEN-1:0]  i_insn_a,
    input  wire  [`SS_XLEN-1:0]  i_insn_b,
    input  ss_pkg::ss_fwd_t      i_x_fwd   [`SS_LANES],
    input  wire  [`SS_XLEN-1:0]  i_rs_data [`SS_LANES],
    input  wire  [`SS_XLEN-1:0]  i_rt_data [`SS_LANES],
    output logic [`SS_XLEN-1:0]  o_pc,
    output logic [`SS_RSEL-1:0]  o_rs_sel  [`SS_LANES],
    output logic [`SS_RSEL-1:0]  o_rt_sel  [`SS_LANES],
    output ss_pkg::ss_issue_t    o_issue   [`SS_LANES]
);

    logic [`SS_XLEN-1:0]  pc_q;
    logic                 d_valid;
    logic [`SS_XLEN-1:0]  d_pc   [`SS_LANES];
    ss_pkg::ss_insn_u     d_insn [`SS_LANES];
    ss_pkg::ss_ctrl_t     d_ctrl [`SS_LANES];
    logic [`SS_LANES-1:0] d_load_use;
    logic                 load_use;
    logic                 b_needs_a;
    logic                 both_mem;
    logic                 split;
    logic [`SS_LANES-1:0] issue_ok;

    function automatic logic reads_reg(input ss_pkg::ss_ctrl_t c,
                                       input logic [`SS_RSEL-1:0] rd);
        return (c.rs_re && c.rs_sel == rd) || (c.rt_re && c.rt_sel == rd);
    endfunction

    assign o_pc = pc_q;

    always_comb begin
        for (int i = 0; i < `SS_LANES; i++) begin
            d_ctrl[i]     = ss_pkg::ss_decode(d_insn[i]);
            o_rs_sel[i]   = d_ctrl[i].rs_sel;
            o_rt_sel[i]   = d_ctrl[i].rt_sel;
            d_load_use[i] = 1'b0;
            // a load in X has no data until the end of M
            for (int j = 0; j < `SS_LANES; j++) begin
                if (i_x_fwd[j].we && i_x_fwd[j].is_load && reads_reg(d_ctrl[i], i_x_fwd[j].rd)) begin
                    d_load_use[i] = 1'b1;
                end
            end
        end
        load_use  = d_valid && (|d_load_use);

        // no bypass inside a pair, and only one data memory port
        b_needs_a = d_ctrl[0].rd_we && reads_reg(d_ctrl[1], d_ctrl[0].rd_sel);
        both_mem  = (d_ctrl[0].is_load || d_ctrl[0].is_store)
                 && (d_ctrl[1].is_load || d_ctrl[1].is_store);
        split     = b_needs_a || both_mem;

        issue_ok[0] = d_valid && !load_use;
        issue_ok[1] = issue_ok[0] && !split;
    end

    always_comb begin
        for (int i = 0; i < `SS_LANES; i++) begin
            o_issue[i] = '0;
            if (issue_ok[i]) begin
                o_issue[i] = '{valid:   1'b1,
                               pc:      d_pc[i],
                               insn:    d_insn[i],
                               ctrl:    d_ctrl[i],
                               rs_data: i_rs_data[i],
                               rt_data: i_rt_data[i]};
            end
        end
    end

    // D holds NOPs after reset, so nothing issues until the first fetch lands
    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q    <= `SS_RESET_PC;
            d_valid <= 1'b0;
            for (int i = 0; i < `SS_LANES; i++) begin
                d_pc[i]   <= '0;
                d_insn[i] <= '0;
            end
        end else if (!load_use) begin
            d_valid <= 1'b1;
            if (split) begin
                // B becomes the older slot, the word at o_pc joins it
                pc_q      <= pc_q + `SS_XLEN'd1;
                d_pc[0]   <= d_pc[1];
                d_insn[0] <= d_insn[1];
                d_pc[1]   <= pc_q;
                d_insn[1] <= i_insn_a;
            end else begin
                pc_q      <= pc_q + `SS_XLEN'd2;
                d_pc[0]   <= pc_q;
                d_insn[0] <= i_insn_a;
                d_pc[1]   <= pc_q + `SS_XLEN'd1;
                d_insn[1] <= i_insn_b;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/ss_pkg.sv */
`default_nettype none

`include "ss_cfg.svh"

package ss_pkg;

    // register form of an LC4 word
    typedef struct packed {
        logic [3:0]          opcode;
        logic [`SS_RSEL-1:0] rd;
        logic [`SS_RSEL-1:0] rs;
        logic [2:0]          subop;
        logic [`SS_RSEL-1:0] rt;
    } ss_rfmt_t;

    // immediate form
    // bit 5 of imm6 marks the immediate ALU variants
    typedef struct packed {
        logic [3:0]          opcode;
        logic [`SS_RSEL-1:0] rd;
        logic [`SS_RSEL-1:0] rs;
        logic [5:0]          imm6;
    } ss_ifmt_t;

    typedef union packed {
        ss_rfmt_t r;
        ss_ifmt_t i;
    } ss_insn_u;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_imm,
        alu_addr
    } ss_alu_op_e;

    typedef struct packed {
        logic [`SS_RSEL-1:0] rs_sel;
        logic [`SS_RSEL-1:0] rt_sel;
        logic [`SS_RSEL-1:0] rd_sel;
        logic                rs_re;
        logic                rt_re;
        logic                rd_we;
        logic                is_load;
        logic                is_store;
        ss_alu_op_e          alu_op;
        logic [`SS_XLEN-1:0] imm;
    } ss_ctrl_t;

    typedef struct packed {
        logic                valid;
        logic [`SS_XLEN-1:0] pc;
        ss_insn_u            insn;
        ss_ctrl_t            ctrl;
        logic [`SS_XLEN-1:0] rs_data;
        logic [`SS_XLEN-1:0] rt_data;
    } ss_issue_t;

    typedef struct packed {
        logic                we;
        logic [`SS_RSEL-1:0] rd;
        logic                is_load;
        logic [`SS_XLEN-1:0] value;
    } ss_fwd_t;

    typedef struct packed {
        logic                valid;
        logic                we;
        logic [`SS_XLEN-1:0] addr;
        logic [`SS_XLEN-1:0] wdata;
    } ss_mem_req_t;

    typedef struct packed {
        logic                valid;
        logic [`SS_XLEN-1:0] pc;
        ss_insn_u            insn;
        logic                rd_we;
        logic [`SS_RSEL-1:0] rd;
        logic [`SS_XLEN-1:0] data;
    } ss_retire_t;

    function automatic ss_ctrl_t ss_decode(input ss_insn_u insn);
        ss_ctrl_t c;
        c        = '0;
        c.rs_sel = insn.r.rs;
        c.rt_sel = insn.r.rt;
        c.rd_sel = insn.r.rd;
        c.imm    = {{(`SS_XLEN-6){insn.i.imm6[5]}}, insn.i.imm6};
        case (insn.r.opcode)
            4'b0001, 4'b0101: begin
                c.rs_re = 1'b1;
                c.rd_we = 1'b1;
                c.rt_re = ~insn.i.imm6[5];
                c.imm   = {{(`SS_XLEN-5){insn.i.imm6[4]}}, insn.i.imm6[4:0]};
                case ({insn.r.opcode[2], insn.r.subop})
                    4'b0000, 4'b0100, 4'b0101, 4'b0110, 4'b0111: c.alu_op = alu_add;
                    4'b0010: c.alu_op = alu_sub;
                    4'b1000, 4'b1100, 4'b1101, 4'b1110, 4'b1111: c.alu_op = alu_and;
                    4'b1010: c.alu_op = alu_or;
                    4'b1011: c.alu_op = alu_xor;
                    // MUL, DIV and NOT are not supported
                    default: c = '0;
                endcase
            end
            4'b1001: begin
                c.rd_we  = 1'b1;
                c.alu_op = alu_pass_imm;
                c.imm    = {{(`SS_XLEN-9){insn.i.rs[2]}}, insn.i.rs, insn.i.imm6};
            end
            4'b0110: begin
                c.rs_re   = 1'b1;
                c.rd_we   = 1'b1;
                c.is_load = 1'b1;
                c.alu_op  = alu_addr;
            end
            4'b0111: begin
                // store data register sits in the rd field
                c.rt_sel   = insn.i.rd;
                c.rs_re    = 1'b1;
                c.rt_re    = 1'b1;
                c.is_store = 1'b1;
                c.alu_op   = alu_addr;
            end
            default: c = '0;
        endcase
        return c;
    endfunction

endpackage

`default_nettype wire

/* verilog/ss_cfg.svh */
`ifndef SS_CFG_SVH
`define SS_CFG_SVH

// data path and address width
`define SS_XLEN 16

// architectural registers and their select width
`define SS_NREG 8
`define SS_RSEL 3

// issue width, the pairing rules assume two
`define SS_LANES 2

// first fetch address after reset
`define SS_RESET_PC 16'h8200

`endif
